/* all.f */
+incdir+testbench
hw/move_sort_pkg.sv
hw/move_ram.sv
hw/move_sort.sv
hw/move_collector.sv
hw/move_reader.sv
hw/move_list_top.sv
testbench/tb_move_list.sv

/* hw/move_collector.sv */
`timescale 1ns/10ps

module move_collector #(
   parameter int MAX_POSITIONS_LOG2 = 6
) (
   input  logic                           clk,
   input  logic                           reset,

   input  logic                           list_open,
   input  logic                           list_close,
   input  logic                           move_valid,
   input  move_sort_pkg::move_entry_t     move_in,

   input  logic [MAX_POSITIONS_LOG2-1:0]  ram_wr_addr,
   input  logic                           sort_complete,

   output logic                           ram_wr_addr_init,
   output logic                           ram_wr,
   output move_sort_pkg::move_entry_t     ram_wr_data,
   output logic                           sort_start,
   output logic                           overflow
);

   localparam logic [MAX_POSITIONS_LOG2-1:0] CAPACITY = '1;

   logic                          list_is_open;
   logic                          close_seen;
   logic                          accept;
   logic [MAX_POSITIONS_LOG2-1:0] fill;

   assign ram_wr_addr_init = list_open;
   assign accept           = list_is_open && move_valid;

   // Count including the write still in flight
   assign fill = ram_wr_addr + MAX_POSITIONS_LOG2'(ram_wr);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         list_is_open <= 1'b0;
         close_seen   <= 1'b0;
         ram_wr       <= 1'b0;
         sort_start   <= 1'b0;
         overflow     <= 1'b0;
      end
      else
      begin
         ram_wr     <= accept && fill != CAPACITY;
         close_seen <= list_close && list_is_open;
         if (list_open)
         begin
            list_is_open <= 1'b1;
            overflow     <= 1'b0;
         end
         else if (list_close)
            list_is_open <= 1'b0;
         if (accept && fill == CAPACITY)
            overflow <= 1'b1;
         // One cycle late so the last write is counted
         if (close_seen)
            sort_start <= 1'b1;
         else if (sort_complete)
            sort_start <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         ram_wr_data <= move_in;
   end

   assert property (@(posedge clk) disable iff (reset) list_close |-> list_is_open)
      else $error("move_collector: list_close with no list open");

endmodule

/* hw/move_list_top.sv */
`timescale 1ns/10ps

module move_list_top #(
   parameter int MAX_POSITIONS_LOG2 = 5
) (
   input  logic                        clk,
   input  logic                        reset,

   input  logic                        list_open,
   input  logic                        list_close,
   input  logic                        move_valid,
   input  move_sort_pkg::move_entry_t  move_in,
   input  logic                        white_to_move,

   output logic                        out_valid,
   output move_sort_pkg::move_entry_t  out_entry,
   output logic                        out_last,
   output logic                        list_done,
   output logic                        overflow
);

   logic                          ram_wr_addr_init;
   logic                          ram_wr;
   move_sort_pkg::move_entry_t    ram_wr_data;
   logic                          sort_start;
   logic [MAX_POSITIONS_LOG2-1:0] ram_wr_addr;
   logic                          sort_complete;
   move_sort_pkg::move_entry_t    ram_rd_data;
   logic [MAX_POSITIONS_LOG2-1:0] ram_rd_addr;
   logic                          sort_clear;

   move_collector #(
      .MAX_POSITIONS_LOG2 (MAX_POSITIONS_LOG2)
   ) u_move_collector (
      .clk              (clk),
      .reset            (reset),
      .list_open        (list_open),
      .list_close       (list_close),
      .move_valid       (move_valid),
      .move_in          (move_in),
      .ram_wr_addr      (ram_wr_addr),
      .sort_complete    (sort_complete),
      .ram_wr_addr_init (ram_wr_addr_init),
      .ram_wr           (ram_wr),
      .ram_wr_data      (ram_wr_data),
      .sort_start       (sort_start),
      .overflow         (overflow)
   );

   move_sort #(
      .MAX_POSITIONS_LOG2 (MAX_POSITIONS_LOG2)
   ) u_move_sort (
      .clk              (clk),
      .reset            (reset),
      .sort_start       (sort_start),
      .sort_clear       (sort_clear),
      .white_to_move    (white_to_move),
      .ram_wr_addr_init (ram_wr_addr_init),
      .ram_wr           (ram_wr),
      .ram_wr_data      (ram_wr_data),
      .ram_rd_addr      (ram_rd_addr),
      .ram_rd_data      (ram_rd_data),
      .ram_wr_addr      (ram_wr_addr),
      .sort_complete    (sort_complete)
   );

   move_reader #(
      .MAX_POSITIONS_LOG2 (MAX_POSITIONS_LOG2)
   ) u_move_reader (
      .clk           (clk),
      .reset         (reset),
      .sort_complete (sort_complete),
      .count         (ram_wr_addr),
      .ram_rd_data   (ram_rd_data),
      .ram_rd_addr   (ram_rd_addr),
      .sort_clear    (sort_clear),
      .out_valid     (out_valid),
      .out_entry     (out_entry),
      .out_last      (out_last),
      .list_done     (list_done)
   );

endmodule

/* hw/move_ram.sv */
`timescale 1ns/10ps

module move_ram #(
   parameter int MAX_POSITIONS_LOG2 = 6
) (
   input  logic                                 clk,

   input  logic                                 a_wr_en,
   input  logic [MAX_POSITIONS_LOG2-1:0]        a_addr,
   input  logic [move_sort_pkg::ENTRY_WIDTH-1:0] a_wr_data,

   input  logic                                 b_wr_en,
   input  logic [MAX_POSITIONS_LOG2-1:0]        b_addr,
   input  logic [move_sort_pkg::ENTRY_WIDTH-1:0] b_wr_data,

   output logic [move_sort_pkg::ENTRY_WIDTH-1:0] a_rd_data,
   output logic [move_sort_pkg::ENTRY_WIDTH-1:0] b_rd_data
);

   logic [move_sort_pkg::ENTRY_WIDTH-1:0] mem [0:(1 << MAX_POSITIONS_LOG2)-1];

   // Read-first on both ports
   always_ff @(posedge clk)
   begin
      if (a_wr_en)
         mem[a_addr] <= a_wr_data;
      if (b_wr_en)
         mem[b_addr] <= b_wr_data;
      a_rd_data <= mem[a_addr];
      b_rd_data <= mem[b_addr];
   end

   // Both ports writing one word would leave it undefined
   assert property (@(posedge clk) !(a_wr_en && b_wr_en && a_addr == b_addr))
      else $error("move_ram: both ports write address %0d", a_addr);

endmodule

/* hw/move_reader.sv */
`timescale 1ns/10ps

module move_reader #(
   parameter int MAX_POSITIONS_LOG2 = 6
) (
   input  logic                           clk,
   input  logic                           reset,

   input  logic                           sort_complete,
   input  logic [MAX_POSITIONS_LOG2-1:0]  count,
   input  move_sort_pkg::move_entry_t     ram_rd_data,

   output logic [MAX_POSITIONS_LOG2-1:0]  ram_rd_addr,
   output logic                           sort_clear,

   output logic                           out_valid,
   output move_sort_pkg::move_entry_t     out_entry,
   output logic                           out_last,
   output logic                           list_done
);

   typedef enum logic [1:0] {
      rd_idle,
      rd_issue,
      rd_wait
   } rd_state_t;

   rd_state_t state;

   logic [MAX_POSITIONS_LOG2-1:0] rd_addr;
   logic start;
   logic issue;
   logic issue_last;
   logic data_valid;
   logic data_last;
   logic empty_done;

   // Address 0 goes out in the same cycle sort_complete is seen
   assign start       = (state == rd_idle) && sort_complete;
   assign issue       = (start && count != '0) || (state == rd_issue);
   assign issue_last  = issue && (rd_addr == count - 1'b1);
   assign ram_rd_addr = rd_addr;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state      <= rd_idle;
         rd_addr    <= '0;
         data_valid <= 1'b0;
         data_last  <= 1'b0;
         out_valid  <= 1'b0;
         out_last   <= 1'b0;
         empty_done <= 1'b0;
         list_done  <= 1'b0;
         sort_clear <= 1'b0;
      end
      else
      begin
         // RAM latency stage, then output stage
         data_valid <= issue;
         data_last  <= issue_last;
         out_valid  <= data_valid;
         out_last   <= data_last;
         empty_done <= start && count == '0;
         list_done  <= out_last || empty_done;
         sort_clear <= out_last || empty_done;
         case (state)
            rd_idle:
            begin
               if (start)
               begin
                  if (count == '0 || issue_last)
                     state <= rd_wait;
                  else
                  begin
                     state   <= rd_issue;
                     rd_addr <= rd_addr + 1'b1;
                  end
               end
            end
            rd_issue:
            begin
               if (issue_last)
               begin
                  state   <= rd_wait;
                  rd_addr <= '0;
               end
               else
                  rd_addr <= rd_addr + 1'b1;
            end
            rd_wait:
            begin
               // Hold off until the sorter has dropped sort_complete
               if (!sort_complete)
                  state <= rd_idle;
            end
            default:
               state <= rd_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (data_valid)
         out_entry <= ram_rd_data;
   end

endmodule

/* hw/move_sort.sv */
`timescale 1ns/10ps

module move_sort #(
   parameter int MAX_POSITIONS_LOG2 = 6
) (
   input  logic                           clk,
   input  logic                           reset,

   input  logic                           sort_start,
   input  logic                           sort_clear,
   input  logic                           white_to_move,

   input  logic                           ram_wr_addr_init,
   input  logic                           ram_wr,
   input  move_sort_pkg::move_entry_t     ram_wr_data,
   input  logic [MAX_POSITIONS_LOG2-1:0]  ram_rd_addr,

   output move_sort_pkg::move_entry_t     ram_rd_data,
   output logic [MAX_POSITIONS_LOG2-1:0]  ram_wr_addr,
   output logic                           sort_complete
);

   move_sort_pkg::sort_state_t state;

   logic sort_start_z;
   logic start_edge;
   logic sort_active;
   logic b_first;

   logic [MAX_POSITIONS_LOG2-1:0] n;
   logic [MAX_POSITIONS_LOG2-1:0] newn;

   logic [MAX_POSITIONS_LOG2-1:0] port_a_addr;
   logic                          port_a_wr_en;
   move_sort_pkg::move_entry_t    port_a_wr_data;

   logic [MAX_POSITIONS_LOG2-1:0] port_b_addr;
   logic                          port_b_wr_en;
   move_sort_pkg::move_entry_t    port_b_wr_data;

   logic [MAX_POSITIONS_LOG2-1:0] ram_a_addr;
   logic                          ram_a_wr_en;
   move_sort_pkg::move_entry_t    ram_a_wr_data;
   logic [MAX_POSITIONS_LOG2-1:0] ram_b_addr;
   logic                          ram_b_wr_en;

   move_sort_pkg::move_entry_t    ent_a;
   move_sort_pkg::move_entry_t    ent_b;

   assign start_edge = sort_start && !sort_start_z;

   // Outside of a sort the collector owns port a and the reader owns port b
   assign sort_active = (state != move_sort_pkg::idle) && (state != move_sort_pkg::done);

   assign ram_a_addr    = sort_active ? port_a_addr : ram_wr_addr;
   assign ram_a_wr_en   = sort_active ? port_a_wr_en : ram_wr;
   assign ram_a_wr_data = sort_active ? port_a_wr_data : ram_wr_data;
   assign ram_b_addr    = sort_active ? port_b_addr : ram_rd_addr;
   assign ram_b_wr_en   = sort_active && port_b_wr_en;

   assign ram_rd_data = ent_b;

   // Entry b belongs ahead of entry a for the side to move
   always_comb
   begin
      if (white_to_move)
         b_first = ($signed(ent_b.eval) > $signed(ent_a.eval)) ||
                   (ent_b.eval == ent_a.eval && ent_b.black_in_check &&
                    !ent_a.black_in_check);
      else
         b_first = ($signed(ent_b.eval) < $signed(ent_a.eval)) ||
                   (ent_b.eval == ent_a.eval && ent_b.white_in_check &&
                    !ent_a.white_in_check);
   end

   // Fill pointer
   always_ff @(posedge clk)
   begin
      if (reset)
         ram_wr_addr <= '0;
      else if (ram_wr_addr_init)
         ram_wr_addr <= '0;
      else if (ram_wr)
         ram_wr_addr <= ram_wr_addr + 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= move_sort_pkg::idle;
         sort_start_z  <= 1'b0;
         sort_complete <= 1'b0;
         port_a_wr_en  <= 1'b0;
         port_b_wr_en  <= 1'b0;
      end
      else
      begin
         sort_start_z <= sort_start;
         case (state)
            move_sort_pkg::idle:
            begin
               port_a_wr_en <= 1'b0;
               port_b_wr_en <= 1'b0;
               n            <= ram_wr_addr;
               if (start_edge)
               begin
                  if (ram_wr_addr <= 1)
                     state <= move_sort_pkg::done;
                  else
                     state <= move_sort_pkg::outer_init;
               end
            end
            move_sort_pkg::outer_init:
            begin
               newn        <= '0;
               port_a_addr <= '0;
               port_b_addr <= 1;
               state       <= move_sort_pkg::read_wait;
            end
            move_sort_pkg::read_wait:
               state <= move_sort_pkg::compare;
            move_sort_pkg::compare:
            begin
               if (b_first)
               begin
                  // Swap by writing both ports at once
                  port_a_wr_en   <= 1'b1;
                  port_b_wr_en   <= 1'b1;
                  port_a_wr_data <= ent_b;
                  port_b_wr_data <= ent_a;
                  newn           <= port_b_addr;
                  state          <= move_sort_pkg::inner;
               end
               else
               begin
                  port_a_addr <= port_a_addr + 1'b1;
                  port_b_addr <= port_b_addr + 1'b1;
                  if (port_b_addr == n - 1'b1)
                     state <= move_sort_pkg::outer_check;
                  else
                     state <= move_sort_pkg::read_wait;
               end
            end
            move_sort_pkg::inner:
            begin
               port_a_wr_en <= 1'b0;
               port_b_wr_en <= 1'b0;
               port_a_addr  <= port_a_addr + 1'b1;
               port_b_addr  <= port_b_addr + 1'b1;
               if (port_b_addr == n - 1'b1)
                  state <= move_sort_pkg::outer_check;
               else
                  state <= move_sort_pkg::read_wait;
            end
            move_sort_pkg::outer_check:
            begin
               // Everything past the last swap is already in place
               n <= newn;
               if (newn > 1)
                  state <= move_sort_pkg::outer_init;
               else
                  state <= move_sort_pkg::done;
            end
            move_sort_pkg::done:
            begin
               sort_complete <= 1'b1;
               if (sort_clear)
               begin
                  sort_complete <= 1'b0;
                  state         <= move_sort_pkg::idle;
               end
            end
            default:
               state <= move_sort_pkg::idle;
         endcase
      end
   end

   move_ram #(
      .MAX_POSITIONS_LOG2 (MAX_POSITIONS_LOG2)
   ) u_move_ram (
      .clk       (clk),
      .a_wr_en   (ram_a_wr_en),
      .a_addr    (ram_a_addr),
      .a_wr_data (ram_a_wr_data),
      .b_wr_en   (ram_b_wr_en),
      .b_addr    (ram_b_addr),
      .b_wr_data (port_b_wr_data),
      .a_rd_data (ent_a),
      .b_rd_data (ent_b)
   );

   assert property (@(posedge clk) disable iff (reset) sort_active |-> !ram_wr)
      else $error("move_sort: external write while sorting");

   assert property (@(posedge clk) disable iff (reset)
                    sort_complete |-> state == move_sort_pkg::done)
      else $error("move_sort: sort_complete outside done");

endmodule

/* hw/move_sort_pkg.sv */
package move_sort_pkg;

   localparam int EVAL_WIDTH = 16;

   // Signed centipawns, compared with $signed
   typedef logic [EVAL_WIDTH-1:0] eval_t;

   // Board square 0 to 63
   typedef logic [5:0] square_t;

   // One RAM word
   typedef struct packed {
      square_t from_sq;
      square_t to_sq;
      logic    white_in_check;
      logic    black_in_check;
      eval_t   eval;
   } move_entry_t;

   localparam int ENTRY_WIDTH = 2 * $bits(square_t) + 2 + EVAL_WIDTH;

   typedef enum logic [2:0] {
      idle,
      outer_init,
      read_wait,
      compare,
      inner,
      outer_check,
      done
   } sort_state_t;

endpackage

/* run.sh */
#!/usr/bin/env bash
# Build and run the move list testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "Cannot enter the project directory"
   exit 1
fi

log_file=sim.log
rm -f "$log_file"

verilator --binary --assert --top-module tb_move_list -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_move_list > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
fi

grep -qx "No errors" "$log_file"
if [ $? -eq 0 ]; then
   echo "Simulation passed"
   exit 0
fi

echo "Simulation failed, see $log_file"
exit 1

/* testbench/tb_move_list_ref.svh */
`ifndef TB_MOVE_LIST_REF_SVH
`define TB_MOVE_LIST_REF_SVH

// True when a belongs strictly ahead of b for the side to move
function automatic logic comes_first(input move_sort_pkg::move_entry_t a,
                                     input move_sort_pkg::move_entry_t b,
                                     input logic white);
   int   ea;
   int   eb;
   logic flag_a;
   logic flag_b;
   ea     = int'($signed(a.eval));
   eb     = int'($signed(b.eval));
   flag_a = white ? a.black_in_check : a.white_in_check;
   flag_b = white ? b.black_in_check : b.white_in_check;
   // Black wants the lowest eval first
   if (!white)
   begin
      ea = -ea;
      eb = -eb;
   end
   if (ea != eb)
      return ea > eb;
   return flag_a && !flag_b;
endfunction

// Stable insertion sort
function automatic entry_q_t sort_reference(input entry_q_t moves, input logic white);
   entry_q_t result;
   int       pos;
   foreach (moves[i])
   begin
      pos = result.size();
      while (pos > 0 && comes_first(moves[i], result[pos-1], white))
         pos--;
      result.insert(pos, moves[i]);
   end
   return result;
endfunction

function automatic entry_q_t reverse_list(input entry_q_t moves);
   entry_q_t result;
   foreach (moves[i])
      result.push_front(moves[i]);
   return result;
endfunction

// span 0 gives full-range evals, a small span gives many ties
function automatic entry_q_t random_list(input int count, input int span);
   entry_q_t                   result;
   move_sort_pkg::move_entry_t entry;
   for (int i = 0; i < count; i++)
   begin
      entry.from_sq        = move_sort_pkg::square_t'(i);
      entry.to_sq          = move_sort_pkg::square_t'($urandom_range(63));
      entry.white_in_check = 1'($urandom_range(1));
      entry.black_in_check = 1'($urandom_range(1));
      if (span == 0)
         entry.eval = move_sort_pkg::eval_t'($urandom);
      else
         entry.eval = move_sort_pkg::eval_t'(int'($urandom_range(span - 1)) - span / 2);
      result.push_back(entry);
   end
   return result;
endfunction

task automatic check_value(input string what, input logic [63:0] actual,
                           input logic [63:0] expected);
   if (actual !== expected)
   begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("Errors found");
      $fatal(1);
   end
endtask

task automatic wait_list_done();
   @(negedge clk);
   while (list_done !== 1'b1)
      @(negedge clk);
   // One more cycle so the monitor closes out this list
   @(negedge clk);
endtask

`endif

/* testbench/tb_move_list.sv */
`timescale 1ns/10ps

module tb_move_list;

   localparam int MAX_POSITIONS_LOG2 = 5;
   localparam int CAPACITY = (1 << MAX_POSITIONS_LOG2) - 1;

   typedef move_sort_pkg::move_entry_t entry_q_t[$];

   logic clk;
   logic reset;
   logic list_open;
   logic list_close;
   logic move_valid;
   logic white_to_move;
   logic out_valid;
   logic out_last;
   logic list_done;
   logic overflow;
   move_sort_pkg::move_entry_t move_in;
   move_sort_pkg::move_entry_t out_entry;

   entry_q_t expected_q;
   logic     expect_overflow;
   logic     open_sampled;
   int       rx_count = 0;
   int       error_count = 0;
   int       cycle_count = 0;
   int       cycle_limit;

   `include "tb_move_list_ref.svh"

   move_list_top #(
      .MAX_POSITIONS_LOG2 (MAX_POSITIONS_LOG2)
   ) DUT (
      .clk           (clk),
      .reset         (reset),
      .list_open     (list_open),
      .list_close    (list_close),
      .move_valid    (move_valid),
      .move_in       (move_in),
      .white_to_move (white_to_move),
      .out_valid     (out_valid),
      .out_entry     (out_entry),
      .out_last      (out_last),
      .list_done     (list_done),
      .overflow      (overflow)
   );

   always #5 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("Timeout: list_done did not arrive within %0d cycles", cycle_limit);
         $display("Errors found");
         $fatal(1);
      end
   end

   always @(posedge clk)
      open_sampled <= list_open;

   // Output monitor
   always @(negedge clk)
   begin
      if (!reset)
      begin
         if (open_sampled)
            check_value("overflow after list_open", 64'(overflow), 64'(0));
         check_value("out_last without out_valid", 64'(out_last && !out_valid), 64'(0));
         if (out_valid)
         begin
            if (rx_count < expected_q.size())
            begin
               check_value("sorted entry", 64'(out_entry), 64'(expected_q[rx_count]));
               check_value("out_last", 64'(out_last),
                           64'(rx_count == expected_q.size() - 1));
            end
            else
               check_value("entries beyond list length", 64'(rx_count + 1),
                           64'(expected_q.size()));
            rx_count = rx_count + 1;
         end
         if (list_done)
         begin
            check_value("entry count at list_done", 64'(rx_count), 64'(expected_q.size()));
            check_value("overflow at list_done", 64'(overflow), 64'(expect_overflow));
            rx_count = 0;
         end
      end
   end

   task automatic run_list(input entry_q_t moves, input logic white, input logic stray);
      entry_q_t kept;
      entry_q_t stray_q;
      for (int i = 0; i < moves.size() && i < CAPACITY; i++)
         kept.push_back(moves[i]);
      expected_q      = sort_reference(kept, white);
      expect_overflow = moves.size() > CAPACITY;
      cycle_limit     = cycle_limit + moves.size() * moves.size() * 3 + 100;
      @(negedge clk);
      white_to_move = white;
      list_open     = 1'b1;
      @(negedge clk);
      list_open = 1'b0;
      foreach (moves[i])
      begin
         move_valid = 1'b1;
         move_in    = moves[i];
         @(negedge clk);
      end
      move_valid = 1'b0;
      list_close = 1'b1;
      @(negedge clk);
      list_close = 1'b0;
      // The list is closed so this move has to be ignored
      if (stray)
      begin
         stray_q    = random_list(1, 0);
         move_valid = 1'b1;
         move_in    = stray_q[0];
         @(negedge clk);
         move_valid = 1'b0;
      end
      wait_list_done();
   endtask

   initial
   begin
      entry_q_t base;
      entry_q_t list_q;
      cycle_limit   = 100;
      clk           = 1'b0;
      reset         = 1'b1;
      list_open     = 1'b0;
      list_close    = 1'b0;
      move_valid    = 1'b0;
      move_in       = '0;
      white_to_move = 1'b1;
      void'($urandom(32'ha883_818d));
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      for (int k = 0; k < 6; k++)
         run_list(random_list($urandom_range(31, 2), (k % 2 == 0) ? 9 : 0), 1'b1, 1'b0);
      for (int k = 0; k < 6; k++)
         run_list(random_list($urandom_range(31, 2), (k % 2 == 0) ? 9 : 0), 1'b0, 1'b0);

      // All evals equal
      base = random_list(14, 1);
      run_list(base, 1'b1, 1'b0);
      run_list(base, 1'b0, 1'b0);
      list_q = sort_reference(base, 1'b1);
      run_list(list_q, 1'b1, 1'b0);
      run_list(reverse_list(list_q), 1'b1, 1'b0);
      list_q = sort_reference(base, 1'b0);
      run_list(list_q, 1'b0, 1'b0);
      run_list(reverse_list(list_q), 1'b0, 1'b0);

      list_q.delete();
      run_list(list_q, 1'b1, 1'b0);
      run_list(list_q, 1'b0, 1'b0);
      // Room is left in the list so an accepted stray would show up
      run_list(random_list(1, 9), 1'b1, 1'b1);
      run_list(random_list(1, 0), 1'b0, 1'b0);

      run_list(random_list(40, 9), 1'b1, 1'b0);
      run_list(random_list(CAPACITY, 9), 1'b0, 1'b0);

      for (int k = 0; k < 5; k++)
         run_list(random_list($urandom_range(31, 2), 5), k % 2 == 0, 1'b0);

      if (error_count == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule
